//--- source/tenyrPkg.sv
package tenyrPkg;

    localparam int WORD_W    = 32;  // Data and word address width
    localparam int REG_IDX_W = 4;   // Sixteen registers
    localparam int IMM_W     = 12;

    // Register indices with fixed meaning
    localparam logic [REG_IDX_W-1:0] REG_ZERO = 4'h0;  // Reads zero
    localparam logic [REG_IDX_W-1:0] REG_P    = 4'hF;  // Reads PC plus one

    // All-ones word always stops the core
    localparam logic [WORD_W-1:0] ILLEGAL_INSN = 32'hFFFF_FFFF;

    localparam logic [WORD_W-1:0] DEFAULT_RESET_VECTOR = 32'h0000_1000;

    // Opcode field, bits 15:12 of the instruction
    typedef enum logic [3:0] {
        OR    = 4'h0,
        AND   = 4'h1,
        ADD   = 4'h2,
        MUL   = 4'h3,
        RSV4  = 4'h4,  // Reserved
        SHL   = 4'h5,
        CLT   = 4'h6,
        CEQ   = 4'h7,
        CGT   = 4'h8,
        ANDN  = 4'h9,  // X and not Y
        XOR   = 4'hA,
        SUB   = 4'hB,
        XORN  = 4'hC,  // X xor not Y
        SHR   = 4'hD,  // Logical
        CNE   = 4'hE,
        RSV15 = 4'hF   // Reserved
    } aluOp_e;

    // Dereference field, bits 29:28
    typedef enum logic [1:0] {
        REG_WRITE  = 2'd0,  // Z <- rhs
        LOAD       = 2'd1,  // Z <- [rhs]
        STORE_AT_Z = 2'd2,  // [Z] <- rhs
        STORE_Z    = 2'd3   // [rhs] <- Z
    } derefMode_e;

    // One instruction in flight, so a plain sequencer is enough
    typedef enum logic [2:0] {
        FETCH,
        EXEC,
        MEM,
        WRITEBACK,
        HALT
    } coreState_e;

endpackage

//--- source/decodeIf.sv
interface decodeIf;
    import tenyrPkg::*;

    logic [REG_IDX_W-1:0] indexZ;
    logic [REG_IDX_W-1:0] indexX;
    logic [REG_IDX_W-1:0] indexY;
    logic [IMM_W-1:0]     imm;
    aluOp_e               op;
    derefMode_e           deref;
    logic                 opType;   // 0: (X op Y) + I, 1: (X op I) + Y
    logic                 illegal;  // All-ones word or reserved opcode

    modport decoder (
        output indexZ,
        output indexX,
        output indexY,
        output imm,
        output op,
        output deref,
        output opType,
        output illegal
    );

    modport consumer (
        input indexZ,
        input indexX,
        input indexY,
        input imm,
        input op,
        input deref,
        input opType,
        input illegal
    );

endinterface

//--- source/insnDecoder.sv
module insnDecoder (
    input  logic [tenyrPkg::WORD_W-1:0] i_insn,
    decodeIf.decoder                    decoded
);
    import tenyrPkg::*;

    aluOp_e opField;
    logic   reservedOp;
    logic   allOnes;

    // Field layout
    //   30     type
    //   29:28  deref
    //   27:24  Z, 23:20 X, 19:16 Y
    //   15:12  op
    //   11:0   immediate
    assign opField = aluOp_e'(i_insn[15:12]);

    assign decoded.opType = i_insn[30];
    assign decoded.deref  = derefMode_e'(i_insn[29:28]);
    assign decoded.indexZ = i_insn[27:24];
    assign decoded.indexX = i_insn[23:20];
    assign decoded.indexY = i_insn[19:16];
    assign decoded.op     = opField;
    assign decoded.imm    = i_insn[IMM_W-1:0];

    // Bit 31 is otherwise ignored
    assign allOnes    = (i_insn == ILLEGAL_INSN);
    assign reservedOp = (opField == RSV4) || (opField == RSV15);

    assign decoded.illegal = allOnes || reservedOp;

endmodule

//--- source/regFile.sv
module regFile (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic [tenyrPkg::REG_IDX_W-1:0] i_indexX,
    input  logic [tenyrPkg::REG_IDX_W-1:0] i_indexY,
    input  logic [tenyrPkg::REG_IDX_W-1:0] i_indexZ,
    input  logic [tenyrPkg::WORD_W-1:0]    i_pc,
    input  logic                           i_writeEn,
    input  logic [tenyrPkg::WORD_W-1:0]    i_writeData,
    output logic [tenyrPkg::WORD_W-1:0]    o_valueX,
    output logic [tenyrPkg::WORD_W-1:0]    o_valueY,
    output logic [tenyrPkg::WORD_W-1:0]    o_valueZ
);
    import tenyrPkg::*;

    localparam int NUM_REGS = 2 ** REG_IDX_W;

    // Only the general purpose entries have storage
    logic [WORD_W-1:0] regs [1:NUM_REGS-2];
    logic [WORD_W-1:0] readView [NUM_REGS];
    logic              writeOk;

    // Full sixteen-entry view with the two special registers filled in
    always_comb begin
        readView[0] = '0;
        for (int i = 1; i < NUM_REGS - 1; i++) begin
            readView[i] = regs[i];
        end
        readView[NUM_REGS-1] = i_pc + 1;  // P is the next address
    end

    assign o_valueX = readView[i_indexX];
    assign o_valueY = readView[i_indexY];
    assign o_valueZ = readView[i_indexZ];

    // Jumps through P are taken by the core, not here
    assign writeOk = i_writeEn && (i_indexZ != REG_ZERO) && (i_indexZ != REG_P);

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 1; i < NUM_REGS - 1; i++) begin
                regs[i] <= '0;
            end
        end else if (writeOk) begin
            regs[i_indexZ] <= i_writeData;
        end
    end

endmodule

//--- source/execUnit.sv
module execUnit (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        i_enable,
    decodeIf.consumer                   dec,
    input  logic [tenyrPkg::WORD_W-1:0] i_valueX,
    input  logic [tenyrPkg::WORD_W-1:0] i_valueY,
    output logic [tenyrPkg::WORD_W-1:0] o_rhs
);
    import tenyrPkg::*;

    localparam int SHIFT_W = $clog2(WORD_W);

    logic [WORD_W-1:0] immExt;
    logic [WORD_W-1:0] operand;   // O in the reference notation
    logic [WORD_W-1:0] addend;    // A
    logic [WORD_W-1:0] opResult;
    logic              bigShift;  // Amount of WORD_W or more
    logic              lessThan;
    logic              greaterThan;
    logic              isEqual;

    assign immExt = {{(WORD_W - IMM_W){dec.imm[IMM_W-1]}}, dec.imm};

    // Type bit swaps the roles of Y and the immediate
    assign operand = dec.opType ? immExt : i_valueY;
    assign addend  = dec.opType ? i_valueY : immExt;

    assign bigShift = |operand[WORD_W-1:SHIFT_W];

    // Compares are signed
    assign lessThan    = $signed(i_valueX) < $signed(operand);
    assign greaterThan = $signed(i_valueX) > $signed(operand);
    assign isEqual     = (i_valueX == operand);

    always_comb begin
        case (dec.op)
            OR:      opResult = i_valueX | operand;
            AND:     opResult = i_valueX & operand;
            ADD:     opResult = i_valueX + operand;
            MUL:     opResult = i_valueX * operand;  // Low word kept
            SHL:     opResult = bigShift ? '0 : i_valueX << operand[SHIFT_W-1:0];
            CLT:     opResult = {WORD_W{lessThan}};
            CEQ:     opResult = {WORD_W{isEqual}};
            CGT:     opResult = {WORD_W{greaterThan}};
            ANDN:    opResult = i_valueX & ~operand;
            XOR:     opResult = i_valueX ^ operand;
            SUB:     opResult = i_valueX - operand;
            XORN:    opResult = i_valueX ^ ~operand;
            SHR:     opResult = bigShift ? '0 : i_valueX >> operand[SHIFT_W-1:0];
            CNE:     opResult = {WORD_W{!isEqual}};
            default: opResult = '0;  // Reserved, core halts instead
        endcase
    end

    // Captured once per instruction, held through MEM and WRITEBACK
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            o_rhs <= '0;
        end else if (i_enable) begin
            o_rhs <= opResult + addend;
        end
    end

endmodule

//--- source/tenyrCore.sv
module tenyrCore #(
    parameter logic [tenyrPkg::WORD_W-1:0] RESET_VECTOR = tenyrPkg::DEFAULT_RESET_VECTOR
) (
    input  logic                        clk,
    input  logic                        reset_n,

    // Instruction fetch
    output logic                        o_fetchValid,
    output logic [tenyrPkg::WORD_W-1:0] o_fetchAddr,
    input  logic                        i_fetchReady,
    input  logic [tenyrPkg::WORD_W-1:0] i_insnData,

    // Data access
    output logic                        o_memValid,
    output logic                        o_memWrite,
    output logic [tenyrPkg::WORD_W-1:0] o_memAddr,
    output logic [tenyrPkg::WORD_W-1:0] o_memWData,
    input  logic                        i_memReady,
    input  logic [tenyrPkg::WORD_W-1:0] i_memRData,

    output logic                        o_halted
);
    import tenyrPkg::*;

    coreState_e        state;
    coreState_e        nextState;
    logic [WORD_W-1:0] pc;
    logic [WORD_W-1:0] insnReg;
    logic [WORD_W-1:0] loadData;
    logic [WORD_W-1:0] rhs;
    logic [WORD_W-1:0] valueX;
    logic [WORD_W-1:0] valueY;
    logic [WORD_W-1:0] valueZ;
    logic [WORD_W-1:0] writeData;
    logic              fetchDone;
    logic              memDone;
    logic              isMemOp;
    logic              regWriteEn;
    logic              jumping;

    decodeIf dec();

    assign fetchDone = o_fetchValid && i_fetchReady;
    assign memDone   = o_memValid && i_memReady;
    assign isMemOp   = (dec.deref != REG_WRITE);

    // Only REG_WRITE and LOAD target a register
    assign regWriteEn = (state == WRITEBACK)
                        && (dec.deref == REG_WRITE || dec.deref == LOAD);
    assign jumping    = regWriteEn && (dec.indexZ == REG_P);
    assign writeData  = (dec.deref == LOAD) ? loadData : rhs;

    always_comb begin
        nextState = state;
        case (state)
            FETCH:     if (fetchDone) nextState = EXEC;
            EXEC: begin
                if (dec.illegal) begin
                    nextState = HALT;
                end else if (isMemOp) begin
                    nextState = MEM;
                end else begin
                    nextState = WRITEBACK;
                end
            end
            MEM:       if (memDone) nextState = WRITEBACK;
            WRITEBACK: nextState = FETCH;
            default:   nextState = HALT;  // No way out of HALT
        endcase
    end

    // Valids are registered so they stay low through reset
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state        <= FETCH;
            pc           <= RESET_VECTOR;
            o_fetchValid <= 1'b0;
            o_memValid   <= 1'b0;
        end else begin
            state        <= nextState;
            o_fetchValid <= (nextState == FETCH);
            o_memValid   <= (nextState == MEM);
            if (state == WRITEBACK) begin
                pc <= jumping ? writeData : pc + 1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetchDone) insnReg <= i_insnData;
        if (memDone) loadData <= i_memRData;  // Only meaningful for LOAD
    end

    insnDecoder uDecoder (
        .i_insn  (insnReg),
        .decoded (dec)
    );

    regFile uRegFile (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_indexX    (dec.indexX),
        .i_indexY    (dec.indexY),
        .i_indexZ    (dec.indexZ),
        .i_pc        (pc),
        .i_writeEn   (regWriteEn),
        .i_writeData (writeData),
        .o_valueX    (valueX),
        .o_valueY    (valueY),
        .o_valueZ    (valueZ)
    );

    execUnit uExec (
        .clk      (clk),
        .reset_n  (reset_n),
        .i_enable (state == EXEC),
        .dec      (dec),
        .i_valueX (valueX),
        .i_valueY (valueY),
        .o_rhs    (rhs)
    );

    // Address and data follow the deref mode, stable for the whole MEM state
    assign o_memWrite = (dec.deref == STORE_AT_Z) || (dec.deref == STORE_Z);
    assign o_memAddr  = (dec.deref == STORE_AT_Z) ? valueZ : rhs;
    assign o_memWData = (dec.deref == STORE_Z) ? valueZ : rhs;

    assign o_fetchAddr = pc;
    assign o_halted    = (state == HALT);

endmodule

//--- tests/tenyrCore_props.sv
module tenyrCoreProps (
    input logic                        clk,
    input logic                        reset_n,
    input logic                        o_fetchValid,
    input logic                        i_fetchReady,
    input logic [tenyrPkg::WORD_W-1:0] o_fetchAddr,
    input logic                        o_memValid,
    input logic                        i_memReady,
    input logic                        o_memWrite,
    input logic [tenyrPkg::WORD_W-1:0] o_memAddr,
    input logic [tenyrPkg::WORD_W-1:0] o_memWData,
    input logic                        o_halted
);
    timeunit 1ns;
    timeprecision 100ps;

    // Held request keeps its address until accepted
    fetchHeld: assert property (@(posedge clk) disable iff (!reset_n)
        o_fetchValid && !i_fetchReady |=> o_fetchValid && $stable(o_fetchAddr))
        else $error("fetch request changed while stalled");

    memHeld: assert property (@(posedge clk) disable iff (!reset_n)
        o_memValid && !i_memReady |=> o_memValid && $stable(o_memAddr)
            && $stable(o_memWrite) && $stable(o_memWData))
        else $error("data request changed while stalled");

    oneRequest: assert property (@(posedge clk) disable iff (!reset_n)
        !(o_fetchValid && o_memValid))
        else $error("fetch and data requests at once");

    haltSticky: assert property (@(posedge clk) disable iff (!reset_n)
        o_halted |=> o_halted && !o_fetchValid && !o_memValid)
        else $error("core left halt or made a request");

endmodule

bind tenyrCore tenyrCoreProps props (
    .clk          (clk),
    .reset_n      (reset_n),
    .o_fetchValid (o_fetchValid),
    .i_fetchReady (i_fetchReady),
    .o_fetchAddr  (o_fetchAddr),
    .o_memValid   (o_memValid),
    .i_memReady   (i_memReady),
    .o_memWrite   (o_memWrite),
    .o_memAddr    (o_memAddr),
    .o_memWData   (o_memWData),
    .o_halted     (o_halted)
);

//--- tests/tenyrCoreTb.sv
module tenyrCoreTb;
    timeunit 1ns;
    timeprecision 100ps;
    import tenyrPkg::*;

    localparam logic [31:0] START_ADDR = 32'h0000_2400;
    localparam int NUM_RUNS      = 6;
    localparam int PROG_LEN      = 40;             // Random part of each program
    localparam int INSNS_PER_RUN = PROG_LEN + 17;  // Plus 16 stores and the halt
    localparam int CYCLE_LIMIT   = 60 * NUM_RUNS * INSNS_PER_RUN + 100 * NUM_RUNS;

    logic        clk;
    logic        reset_n;
    logic        fetchValid, fetchReady;
    logic [31:0] fetchAddr, insnData;
    logic        memValid, memWrite, memReady;
    logic [31:0] memAddr, memWData, memRData;
    logic        halted;

    logic [31:0] insnMem [logic [31:0]];
    logic [31:0] dataMem [logic [31:0]];
    logic [31:0] modelMem [logic [31:0]];
    logic [31:0] modelRegs [16];
    logic [31:0] modelPc;
    bit          modelHalted;
    bit          expWrite [$];
    logic [31:0] expAddr [$];
    logic [31:0] expData [$];

    logic [31:0] rngState = 32'hf779_d1e0;
    bit          stallOn;
    int          cycleCount;
    int          mismatchCount;
    int          otherCount;

    tenyrCore #(.RESET_VECTOR(START_ADDR)) uut (
        .clk          (clk),
        .reset_n      (reset_n),
        .o_fetchValid (fetchValid),
        .o_fetchAddr  (fetchAddr),
        .i_fetchReady (fetchReady),
        .i_insnData   (insnData),
        .o_memValid   (memValid),
        .o_memWrite   (memWrite),
        .o_memAddr    (memAddr),
        .o_memWData   (memWData),
        .i_memReady   (memReady),
        .i_memRData   (memRData),
        .o_halted     (halted)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    function automatic logic [31:0] nextRand();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    // Untouched data words still differ per address
    function automatic logic [31:0] fillWord(input logic [31:0] addr);
        return (addr * 32'h9E37_79B9) ^ 32'h5BD1_E995;
    endfunction

    function automatic logic [31:0] dataRead(input logic [31:0] addr);
        return dataMem.exists(addr) ? dataMem[addr] : fillWord(addr);
    endfunction

    function automatic logic [31:0] modelRead(input logic [31:0] addr);
        return modelMem.exists(addr) ? modelMem[addr] : fillWord(addr);
    endfunction

    function automatic logic [31:0] fetchWord(input logic [31:0] addr);
        return insnMem.exists(addr) ? insnMem[addr] : 32'hFFFF_FFFF;
    endfunction

    function automatic logic [31:0] makeInsn(input bit t, input logic [1:0] d,
            input logic [3:0] z, input logic [3:0] x, input logic [3:0] y,
            input logic [3:0] op, input logic [11:0] imm);
        return {1'b0, t, d, z, x, y, op, imm};
    endfunction

    // Reference ALU with signed compares and shifts that clear past 31
    function automatic logic [31:0] aluModel(input logic [3:0] op,
            input logic [31:0] x, input logic [31:0] o);
        case (op)
            4'h0: return x | o;
            4'h1: return x & o;
            4'h2: return x + o;
            4'h3: return x * o;
            4'h5: return (o > 31) ? 32'h0 : x << o;
            4'h6: return ($signed(x) < $signed(o)) ? 32'hFFFF_FFFF : 32'h0;
            4'h7: return (x == o) ? 32'hFFFF_FFFF : 32'h0;
            4'h8: return ($signed(x) > $signed(o)) ? 32'hFFFF_FFFF : 32'h0;
            4'h9: return x & ~o;
            4'hA: return x ^ o;
            4'hB: return x - o;
            4'hC: return x ^ ~o;
            4'hD: return (o > 31) ? 32'h0 : x >> o;
            4'hE: return (x != o) ? 32'hFFFF_FFFF : 32'h0;
            default: return 32'h0;
        endcase
    endfunction

    function automatic logic [31:0] modelReg(input logic [3:0] idx);
        if (idx == 4'd0) return 32'h0;
        if (idx == 4'd15) return modelPc + 1;
        return modelRegs[idx];
    endfunction

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
            input string msg);
        if (actual !== expected) begin
            mismatchCount++;
            $display("mismatch at %0t ns: %s, got %h, expected %h",
                     $time, msg, actual, expected);
        end
    endtask

    task automatic modelWrite(input logic [3:0] idx, input logic [31:0] value);
        if (idx == 4'd15) begin
            modelPc = value;  // Jump
        end else begin
            if (idx != 4'd0) modelRegs[idx] = value;
            modelPc = modelPc + 1;
        end
    endtask

    // Model step for one instruction at its fetch
    task automatic executeModel(input logic [31:0] insn);
        logic [31:0] immExt;
        logic [31:0] valX;
        logic [31:0] valY;
        logic [31:0] valZ;
        logic [31:0] rhs;
        logic [3:0]  op;
        op     = insn[15:12];
        immExt = {{20{insn[11]}}, insn[11:0]};
        valX   = modelReg(insn[23:20]);
        valY   = modelReg(insn[19:16]);
        valZ   = modelReg(insn[27:24]);
        if (insn == 32'hFFFF_FFFF || op == 4'd4 || op == 4'd15) begin
            modelHalted = 1'b1;
            return;
        end
        if (insn[30]) rhs = aluModel(op, valX, immExt) + valY;
        else rhs = aluModel(op, valX, valY) + immExt;
        case (insn[29:28])
            2'd0: modelWrite(insn[27:24], rhs);
            2'd1: begin
                expWrite.push_back(1'b0);
                expAddr.push_back(rhs);
                expData.push_back(32'h0);
                modelWrite(insn[27:24], modelRead(rhs));
            end
            2'd2: begin
                expWrite.push_back(1'b1);
                expAddr.push_back(valZ);
                expData.push_back(rhs);
                modelMem[valZ] = rhs;
                modelPc = modelPc + 1;
            end
            default: begin
                expWrite.push_back(1'b1);
                expAddr.push_back(rhs);
                expData.push_back(valZ);
                modelMem[rhs] = valZ;
                modelPc = modelPc + 1;
            end
        endcase
    endtask

    task automatic buildProgram(input int run);
        logic [3:0]  z;
        logic [3:0]  op;
        logic [1:0]  d;
        logic [31:0] insn;
        int          room;
        insnMem.delete();
        dataMem.delete();
        modelMem.delete();
        for (int a = 0; a < 64; a++) begin
            dataMem[a]  = nextRand();
            modelMem[a] = dataMem[a];
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            if (nextRand() % 12 == 0) begin
                // Forward jump whose target P + imm stays inside the program
                room = (PROG_LEN - 1 - i < 3) ? PROG_LEN - 1 - i : 3;
                insn = makeInsn(0, 2'd0, 4'd15, 4'd15, 4'd0, 4'h2, nextRand() % (room + 1));
            end else begin
                d = nextRand() % 4;
                z = (d <= 2'd1) ? nextRand() % 15 : nextRand() % 16;
                do op = nextRand() % 16; while (op == 4'd4 || op == 4'd15);
                insn = makeInsn(nextRand() % 2, d, z, nextRand() % 16, nextRand() % 16,
                                op, nextRand() % 4096);
                if (d != 2'd0 && nextRand() % 2) begin
                    insn = makeInsn(0, d, z, 4'd0, 4'd0, 4'h0, nextRand() % 64);
                end
            end
            insnMem[START_ADDR + i] = insn;
        end
        for (int r = 0; r < 16; r++) begin
            insnMem[START_ADDR + PROG_LEN + r] = makeInsn(0, 2'd3, r, 0, 0, 4'h0, 12'h700 + r);
        end
        if (run % 2 == 0) insn = 32'hFFFF_FFFF;
        else insn = makeInsn(0, 2'd0, 4'd1, 4'd1, 4'd1, (run % 4 == 1) ? 4'd4 : 4'd15, 0);
        insnMem[START_ADDR + PROG_LEN + 16] = insn;
    endtask

    // Inputs change on the falling edge only
    always @(negedge clk) begin
        fetchReady <= stallOn ? (nextRand() % 4 != 0) : 1'b1;
        memReady   <= stallOn ? (nextRand() % 3 != 0) : 1'b1;
        insnData   <= fetchWord(fetchAddr);
        memRData   <= dataRead(memAddr);
    end

    // Memory side and request checks
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("timeout: core did not halt within %0d cycles", CYCLE_LIMIT);
            $display("TEST RESULT: FAIL");
            $finish;
        end else if (reset_n) begin
            if (halted && (fetchValid || memValid)) begin
                otherCount++;
                $display("error at %0t ns: request made after halt", $time);
            end
            if (halted && !modelHalted) begin
                otherCount++;
                $display("error at %0t ns: core halted on a legal instruction", $time);
            end
            if (fetchValid && fetchReady) begin
                checkValue(fetchAddr, modelPc, "fetch address");
                executeModel(fetchWord(fetchAddr));
            end
            if (memValid && memReady) begin
                if (expWrite.size() == 0) begin
                    otherCount++;
                    $display("error at %0t ns: data request that the model did not expect",
                             $time);
                end else begin
                    checkValue(memWrite, expWrite[0], "data write flag");
                    checkValue(memAddr, expAddr[0], "data address");
                    if (expWrite[0]) checkValue(memWData, expData[0], "store data");
                    void'(expWrite.pop_front());
                    void'(expAddr.pop_front());
                    void'(expData.pop_front());
                end
                if (memWrite) dataMem[memAddr] = memWData;
            end
        end
    end

    task automatic runProgram(input int run);
        @(negedge clk);
        reset_n = 1'b0;
        @(posedge clk);
        buildProgram(run);
        stallOn = (run != 0);
        for (int r = 0; r < 16; r++) modelRegs[r] = 32'h0;
        modelPc     = START_ADDR;
        modelHalted = 1'b0;
        expWrite.delete();
        expAddr.delete();
        expData.delete();
        repeat (5) begin
            @(negedge clk);
            checkValue(fetchValid, 1'b0, "fetch valid during reset");
            checkValue(memValid, 1'b0, "data valid during reset");
        end
        reset_n = 1'b1;
        while (!halted) @(negedge clk);
        repeat (20) @(negedge clk);  // Watch for late requests
        if (!modelHalted || expWrite.size() != 0) begin
            otherCount++;
            $display("error: run %0d halted with %0d data requests still expected",
                     run, expWrite.size());
        end
    endtask

    initial begin
        reset_n    = 1'b0;
        fetchReady = 1'b0;
        memReady   = 1'b0;
        insnData   = 32'h0;
        memRData   = 32'h0;
        stallOn    = 1'b0;
        for (int run = 0; run < NUM_RUNS; run++) begin
            runProgram(run);
        end
        $display("errors: %0d mismatches, %0d other", mismatchCount, otherCount);
        if (mismatchCount == 0 && otherCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- tenyrCore.f
source/tenyrPkg.sv
source/decodeIf.sv
source/insnDecoder.sv
source/regFile.sv
source/execUnit.sv
source/tenyrCore.sv
tests/tenyrCore_props.sv
tests/tenyrCoreTb.sv

//--- Bender.yml
package:
  name: tenyrCore

sources:
  - source/tenyrPkg.sv
  - source/decodeIf.sv
  - source/insnDecoder.sv
  - source/regFile.sv
  - source/execUnit.sv
  - source/tenyrCore.sv
  - target: test
    files:
      - tests/tenyrCore_props.sv
      - tests/tenyrCoreTb.sv
